// ==== source/exu_pkg.sv ====
package exu_pkg;

    // datapath widths
    localparam int xlen    = 32;
    localparam int reg_aw  = 5;
    localparam int op_w    = 5;
    localparam int sram_aw = 12;

    // integer ops
    localparam logic [op_w-1:0] op_add   = 5'd0;
    localparam logic [op_w-1:0] op_sub   = 5'd1;
    localparam logic [op_w-1:0] op_slt   = 5'd2;
    localparam logic [op_w-1:0] op_sltu  = 5'd3;
    localparam logic [op_w-1:0] op_xor   = 5'd4;
    localparam logic [op_w-1:0] op_or    = 5'd5;
    localparam logic [op_w-1:0] op_and   = 5'd6;
    localparam logic [op_w-1:0] op_sll   = 5'd7;
    localparam logic [op_w-1:0] op_srl   = 5'd8;
    localparam logic [op_w-1:0] op_sra   = 5'd9;
    localparam logic [op_w-1:0] op_lui   = 5'd10;
    localparam logic [op_w-1:0] op_auipc = 5'd11;

    // control transfer
    localparam logic [op_w-1:0] op_jal   = 5'd12;
    localparam logic [op_w-1:0] op_jalr  = 5'd13;
    localparam logic [op_w-1:0] op_beq   = 5'd14;
    localparam logic [op_w-1:0] op_bne   = 5'd15;
    localparam logic [op_w-1:0] op_blt   = 5'd16;
    localparam logic [op_w-1:0] op_bge   = 5'd17;
    localparam logic [op_w-1:0] op_bltu  = 5'd18;
    localparam logic [op_w-1:0] op_bgeu  = 5'd19;

    // scratchpad loads and stores
    localparam logic [op_w-1:0] op_lb    = 5'd20;
    localparam logic [op_w-1:0] op_lh    = 5'd21;
    localparam logic [op_w-1:0] op_lw    = 5'd22;
    localparam logic [op_w-1:0] op_lbu   = 5'd23;
    localparam logic [op_w-1:0] op_lhu   = 5'd24;
    localparam logic [op_w-1:0] op_sb    = 5'd25;
    localparam logic [op_w-1:0] op_sh    = 5'd26;
    localparam logic [op_w-1:0] op_sw    = 5'd27;
    localparam logic [op_w-1:0] op_nop   = 5'd31;

    // ram type field, code 3 maps to no ram
    localparam logic [1:0] ram_iram = 2'd0;
    localparam logic [1:0] ram_oram = 2'd1;
    localparam logic [1:0] ram_wram = 2'd2;

    typedef union packed {
        logic [xlen-1:0] raw;
        struct packed {
            logic [xlen-sram_aw-3:0] unused;
            logic [1:0]              ram_type;
            logic [sram_aw-1:0]      sram_addr;
        } f;
    } mem_addr_u;

endpackage

// ==== source/exu_ctrl.sv ====
module exu_ctrl
    import exu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            issue_vld,
    input  logic [op_w-1:0] issue_op,
    input  logic            wb_en,
    input  logic            lsu_rdy,
    input  logic            br_taken,
    output logic            accept,
    output logic            issue_rdy,
    output logic            flush,
    output logic            br_vld,
    output logic            rf_wb_vld,
    output logic            ld_pending,
    output logic            is_load,
    output logic            is_store,
    output logic            lsu_vld,
    output logic            lsu_wb_vld
);

    // opcode classes
    assign is_load  = issue_op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    assign is_store = issue_op inside {op_sb, op_sh, op_sw};

    // back-pressure from the lsu stalls issue
    assign issue_rdy = lsu_rdy;
    assign flush     = br_vld;

    // nothing is taken while a redirect is in flight
    assign accept = issue_vld & issue_rdy & ~flush;

    assign rf_wb_vld  = accept & wb_en;
    assign ld_pending = accept & is_load;

    // redirect pulse toward fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            br_vld <= 1'b0;
        end else begin
            br_vld <= accept & br_taken;
        end
    end

    // lsu stage valid, held while the lsu is busy
    always_ff @(posedge clk) begin
        if (reset) begin
            lsu_vld <= 1'b0;
        end else begin
            lsu_vld <= accept | (lsu_vld & ~lsu_rdy);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lsu_wb_vld <= 1'b0;
        end else if (accept) begin
            lsu_wb_vld <= wb_en;
        end else if (lsu_rdy) begin
            lsu_wb_vld <= 1'b0;
        end
    end

endmodule

// ==== source/alu_core.sv ====
module alu_core
    import exu_pkg::*;
(
    input  logic [op_w-1:0] op,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            op_add:   result = src1 + src2;
            op_sub:   result = src1 - src2;
            op_slt:   result = {{(xlen-1){1'b0}}, lt_signed};
            op_sltu:  result = {{(xlen-1){1'b0}}, lt_unsigned};
            op_xor:   result = src1 ^ src2;
            op_or:    result = src1 | src2;
            op_and:   result = src1 & src2;
            op_sll:   result = src1 << shamt;
            op_srl:   result = src1 >> shamt;
            op_sra:   result = $unsigned($signed(src1) >>> shamt);
            // upper immediate arrives already shifted in src2
            op_lui:   result = src2;
            op_auipc: result = pc + src2;
            // link address
            op_jal,
            op_jalr:  result = pc + xlen'(4);
            default:  result = '0;
        endcase
    end

endmodule

// ==== source/branch_unit.sv ====
module branch_unit
    import exu_pkg::*;
#(
    parameter int br_aw = 12
) (
    input  logic             clk,
    input  logic [op_w-1:0]  op,
    input  logic [xlen-1:0]  src1,
    input  logic [xlen-1:0]  src2,
    input  logic [xlen-1:0]  imm,
    input  logic [xlen-1:0]  pc,
    input  logic             accept,
    output logic             br_taken,
    output logic [br_aw-1:0] br_addr
);

    logic [xlen-1:0] target;

    // compare conditions, jumps always taken
    always_comb begin
        case (op)
            op_beq:  br_taken = src1 == src2;
            op_bne:  br_taken = src1 != src2;
            op_blt:  br_taken = $signed(src1) < $signed(src2);
            op_bge:  br_taken = $signed(src1) >= $signed(src2);
            op_bltu: br_taken = src1 < src2;
            op_bgeu: br_taken = src1 >= src2;
            op_jal,
            op_jalr: br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            op_jal:  target = pc + src2;
            op_jalr: target = src1 + src2;
            // conditional branches
            default: target = pc + imm;
        endcase
    end

    // only the low bits go to fetch
    always_ff @(posedge clk) begin
        if (accept) begin
            br_addr <= target[br_aw-1:0];
        end
    end

endmodule

// ==== source/lsu_addr_gen.sv ====
module lsu_addr_gen
    import exu_pkg::*;
(
    input  logic            is_load,
    input  logic            is_store,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic [xlen-1:0] imm,
    output mem_addr_u       mem_addr,
    output logic [2:0]      ld_sel,
    output logic [2:0]      st_sel
);

    logic [2:0] ram_dec;

    // stores keep src2 for data, so their offset comes in imm
    assign mem_addr.raw = is_store ? src1 + imm : src1 + src2;

    always_comb begin
        ram_dec = 3'b000;
        case (mem_addr.f.ram_type)
            ram_iram: ram_dec[ram_iram] = 1'b1;
            ram_oram: ram_dec[ram_oram] = 1'b1;
            ram_wram: ram_dec[ram_wram] = 1'b1;
            default:  ram_dec = 3'b000;
        endcase
    end

    assign ld_sel = is_load  ? ram_dec : 3'b000;
    assign st_sel = is_store ? ram_dec : 3'b000;

endmodule

// ==== source/exu_lsu_reg.sv ====
module exu_lsu_reg
    import exu_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               accept,
    input  logic [reg_aw-1:0]  wb_addr,
    input  logic [xlen-1:0]    result,
    input  logic [op_w-1:0]    op,
    input  mem_addr_u          mem_addr,
    input  logic [2:0]         ld_sel,
    input  logic [2:0]         st_sel,
    input  logic [xlen-1:0]    src2,
    output logic [reg_aw-1:0]  lsu_wb_addr,
    output logic [xlen-1:0]    lsu_wb_data,
    output logic [op_w-1:0]    lsu_mem_op,
    output logic [sram_aw-1:0] lsu_sram_addr,
    output logic               lsu_ld_iram,
    output logic               lsu_ld_oram,
    output logic               lsu_ld_wram,
    output logic               lsu_st_iram,
    output logic               lsu_st_oram,
    output logic               lsu_st_wram,
    output logic [xlen-1:0]    lsu_st_data
);

    logic [2:0] ld_sel_q;
    logic [2:0] st_sel_q;

    // payload, loaded only on accept so it holds through a stall
    always_ff @(posedge clk) begin
        if (accept) begin
            lsu_wb_addr   <= wb_addr;
            lsu_wb_data   <= result;
            lsu_mem_op    <= op;
            lsu_sram_addr <= mem_addr.f.sram_addr;
            lsu_st_data   <= src2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_sel_q <= 3'b000;
            st_sel_q <= 3'b000;
        end else if (accept) begin
            ld_sel_q <= ld_sel;
            st_sel_q <= st_sel;
        end
    end

    assign lsu_ld_iram = ld_sel_q[ram_iram];
    assign lsu_ld_oram = ld_sel_q[ram_oram];
    assign lsu_ld_wram = ld_sel_q[ram_wram];
    assign lsu_st_iram = st_sel_q[ram_iram];
    assign lsu_st_oram = st_sel_q[ram_oram];
    assign lsu_st_wram = st_sel_q[ram_wram];

endmodule

// ==== source/exu_top.sv ====
module exu_top
    import exu_pkg::*;
#(
    parameter int br_aw = 12
) (
    input  logic               clk,
    input  logic               reset,
    // issue from idu
    input  logic               issue_vld,
    input  logic [op_w-1:0]    issue_op,
    input  logic [xlen-1:0]    src1,
    input  logic [xlen-1:0]    src2,
    input  logic [xlen-1:0]    imm,
    input  logic [xlen-1:0]    pc,
    input  logic               wb_en,
    input  logic [reg_aw-1:0]  wb_addr,
    output logic               issue_rdy,
    output logic               flush,
    // register file write-back
    output logic               rf_wb_vld,
    output logic [reg_aw-1:0]  rf_wb_addr,
    output logic [xlen-1:0]    rf_wb_data,
    output logic               ld_pending,
    // redirect to fetch
    output logic               br_vld,
    output logic [br_aw-1:0]   br_addr,
    // lsu stage
    input  logic               lsu_rdy,
    output logic               lsu_vld,
    output logic               lsu_wb_vld,
    output logic [reg_aw-1:0]  lsu_wb_addr,
    output logic [xlen-1:0]    lsu_wb_data,
    output logic [op_w-1:0]    lsu_mem_op,
    output logic [sram_aw-1:0] lsu_sram_addr,
    output logic               lsu_ld_iram,
    output logic               lsu_ld_oram,
    output logic               lsu_ld_wram,
    output logic               lsu_st_iram,
    output logic               lsu_st_oram,
    output logic               lsu_st_wram,
    output logic [xlen-1:0]    lsu_st_data
);

    logic            accept;
    logic            br_taken;
    logic            is_load;
    logic            is_store;
    logic [xlen-1:0] alu_result;
    mem_addr_u       mem_addr;
    logic [2:0]      ld_sel;
    logic [2:0]      st_sel;

    assign rf_wb_addr = wb_addr;
    assign rf_wb_data = alu_result;

    exu_ctrl u_exu_ctrl (
        .clk        (clk),
        .reset      (reset),
        .issue_vld  (issue_vld),
        .issue_op   (issue_op),
        .wb_en      (wb_en),
        .lsu_rdy    (lsu_rdy),
        .br_taken   (br_taken),
        .accept     (accept),
        .issue_rdy  (issue_rdy),
        .flush      (flush),
        .br_vld     (br_vld),
        .rf_wb_vld  (rf_wb_vld),
        .ld_pending (ld_pending),
        .is_load    (is_load),
        .is_store   (is_store),
        .lsu_vld    (lsu_vld),
        .lsu_wb_vld (lsu_wb_vld)
    );

    alu_core u_alu_core (
        .op     (issue_op),
        .src1   (src1),
        .src2   (src2),
        .pc     (pc),
        .result (alu_result)
    );

    branch_unit #(
        .br_aw (br_aw)
    ) u_branch_unit (
        .clk      (clk),
        .op       (issue_op),
        .src1     (src1),
        .src2     (src2),
        .imm      (imm),
        .pc       (pc),
        .accept   (accept),
        .br_taken (br_taken),
        .br_addr  (br_addr)
    );

    lsu_addr_gen u_lsu_addr_gen (
        .is_load  (is_load),
        .is_store (is_store),
        .src1     (src1),
        .src2     (src2),
        .imm      (imm),
        .mem_addr (mem_addr),
        .ld_sel   (ld_sel),
        .st_sel   (st_sel)
    );

    exu_lsu_reg u_exu_lsu_reg (
        .clk           (clk),
        .reset         (reset),
        .accept        (accept),
        .wb_addr       (wb_addr),
        .result        (alu_result),
        .op            (issue_op),
        .mem_addr      (mem_addr),
        .ld_sel        (ld_sel),
        .st_sel        (st_sel),
        .src2          (src2),
        .lsu_wb_addr   (lsu_wb_addr),
        .lsu_wb_data   (lsu_wb_data),
        .lsu_mem_op    (lsu_mem_op),
        .lsu_sram_addr (lsu_sram_addr),
        .lsu_ld_iram   (lsu_ld_iram),
        .lsu_ld_oram   (lsu_ld_oram),
        .lsu_ld_wram   (lsu_ld_wram),
        .lsu_st_iram   (lsu_st_iram),
        .lsu_st_oram   (lsu_st_oram),
        .lsu_st_wram   (lsu_st_wram),
        .lsu_st_data   (lsu_st_data)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int period = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

// ==== sim/exu_checker.sv ====
module exu_checker
    import exu_pkg::*;
#(
    parameter int br_aw     = 12,
    parameter int max_lines = 64
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               end_check,
    input  logic               issue_vld,
    input  logic [op_w-1:0]    issue_op,
    input  logic               issue_rdy,
    input  logic               flush,
    input  logic               rf_wb_vld,
    input  logic [reg_aw-1:0]  rf_wb_addr,
    input  logic [xlen-1:0]    rf_wb_data,
    input  logic               ld_pending,
    input  logic               br_vld,
    input  logic [br_aw-1:0]   br_addr,
    input  logic               lsu_rdy,
    input  logic               lsu_vld,
    input  logic               lsu_wb_vld,
    input  logic [reg_aw-1:0]  lsu_wb_addr,
    input  logic [xlen-1:0]    lsu_wb_data,
    input  logic [op_w-1:0]    lsu_mem_op,
    input  logic [sram_aw-1:0] lsu_sram_addr,
    input  logic               lsu_ld_iram,
    input  logic               lsu_ld_oram,
    input  logic               lsu_ld_wram,
    input  logic               lsu_st_iram,
    input  logic               lsu_st_oram,
    input  logic               lsu_st_wram,
    input  logic [xlen-1:0]    lsu_st_data,
    output int                 mismatch_cnt,
    output int                 other_cnt,
    output int                 items_pending
);

    logic [31:0] g [max_lines][13];
    int          n_lines;
    bit          load_err;
    int          line_idx;
    int          q[$];
    bit          reset_q;
    bit          br_due;
    logic [31:0] br_due_addr;
    bit          stall_q;
    logic [92:0] held_bus;
    logic [92:0] lsu_bus;
    logic [5:0]  sel_bus;
    bit          acc;
    bit          end_done;
    int          k;

    assign sel_bus = {lsu_st_wram, lsu_st_oram, lsu_st_iram,
                      lsu_ld_wram, lsu_ld_oram, lsu_ld_iram};
    assign lsu_bus = {lsu_wb_vld, lsu_wb_addr, lsu_wb_data, lsu_mem_op,
                      lsu_sram_addr, sel_bus, lsu_st_data};

    // column order: op src1 src2 imm pc wb_en wb_addr killed data taken br sram sel
    initial begin
        int    fd;
        int    rc;
        string line;
        mismatch_cnt  = 0;
        other_cnt     = 0;
        items_pending = 0;
        n_lines       = 0;
        line_idx      = 0;
        fd = $fopen("sim/exu_golden.txt", "r");
        load_err = (fd == 0);
        while (fd != 0 && !$feof(fd) && n_lines < max_lines) begin
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                         g[n_lines][0], g[n_lines][1], g[n_lines][2], g[n_lines][3],
                         g[n_lines][4], g[n_lines][5], g[n_lines][6], g[n_lines][7],
                         g[n_lines][8], g[n_lines][9], g[n_lines][10], g[n_lines][11],
                         g[n_lines][12]);
            if (rc == 13) begin
                n_lines++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    end

    function automatic bit op_is_load(input logic [31:0] op);
        return op >= 32'(op_lb) && op <= 32'(op_lhu);
    endfunction

    function automatic bit op_is_store(input logic [31:0] op);
        return op >= 32'(op_sb) && op <= 32'(op_sw);
    endfunction

    task automatic check_val(input string name, input logic [95:0] exp,
                             input logic [95:0] got);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
            mismatch_cnt++;
        end
    endtask

    task automatic report(input string msg);
        $display("at %0t: %s", $time, msg);
        other_cnt++;
    endtask

    // item leaving the lsu stage, compared to its golden line
    task automatic check_delivery(input int i);
        check_val("lsu_wb_vld", 96'(g[i][5][0]), 96'(lsu_wb_vld));
        check_val("lsu_wb_data", 96'(g[i][8]), 96'(lsu_wb_data));
        check_val("lsu ram select", 96'(g[i][12][5:0]), 96'(sel_bus));
        if (op_is_load(g[i][0]) || op_is_store(g[i][0])) begin
            check_val("lsu_mem_op", 96'(g[i][0][4:0]), 96'(lsu_mem_op));
            check_val("lsu_sram_addr", 96'(g[i][11][11:0]), 96'(lsu_sram_addr));
        end
        if (op_is_load(g[i][0])) begin
            check_val("lsu_wb_addr", 96'(g[i][6][4:0]), 96'(lsu_wb_addr));
        end
        if (op_is_store(g[i][0])) begin
            check_val("lsu_st_data", 96'(g[i][2]), 96'(lsu_st_data));
        end
    endtask

    always @(posedge clk) begin
        if (reset_q) begin
            check_val("br_vld", 96'(0), 96'(br_vld));
            check_val("flush", 96'(0), 96'(flush));
            check_val("lsu_vld", 96'(0), 96'(lsu_vld));
            check_val("lsu ram select", 96'(0), 96'(sel_bus));
        end
        if (!reset) begin
            check_val("issue_rdy", 96'(lsu_rdy), 96'(issue_rdy));
            check_val("br_vld", 96'(br_due), 96'(br_vld));
            check_val("flush", 96'(br_due), 96'(flush));
            if (br_due) begin
                check_val("br_addr", 96'(br_due_addr[br_aw-1:0]), 96'(br_addr));
            end
            if (stall_q) begin
                check_val("lsu outputs during stall", 96'(held_bus), 96'(lsu_bus));
            end

            if (q.size() != 0 && !lsu_vld) begin
                report("an accepted item did not reach the LSU stage");
                void'(q.pop_front());
            end else if (lsu_vld && lsu_rdy) begin
                if (q.size() == 0) begin
                    report("LSU stage delivered an item that was never accepted");
                end else begin
                    k = q.pop_front();
                    check_delivery(k);
                end
            end

            acc    = issue_vld && issue_rdy && !flush;
            br_due = 1'b0;
            if (issue_vld && (acc || flush) && line_idx >= n_lines) begin
                report("issue seen beyond the end of the golden file");
            end else if (issue_vld && flush) begin
                if (!g[line_idx][7][0]) begin
                    report($sformatf("line %0d was discarded but not marked killed", line_idx));
                end
                line_idx++;
            end else if (acc) begin
                if (g[line_idx][7][0]) begin
                    report($sformatf("line %0d was accepted though marked killed", line_idx));
                end
                check_val("rf_wb_vld", 96'(g[line_idx][5][0]), 96'(rf_wb_vld));
                check_val("rf_wb_data", 96'(g[line_idx][8]), 96'(rf_wb_data));
                if (g[line_idx][5][0]) begin
                    check_val("rf_wb_addr", 96'(g[line_idx][6][4:0]), 96'(rf_wb_addr));
                end
                check_val("ld_pending", 96'(op_is_load(g[line_idx][0])), 96'(ld_pending));
                br_due      = g[line_idx][9][0];
                br_due_addr = g[line_idx][10];
                q.push_back(line_idx);
                line_idx++;
            end
            if (!acc) begin
                check_val("rf_wb_vld", 96'(0), 96'(rf_wb_vld));
                check_val("ld_pending", 96'(0), 96'(ld_pending));
            end

            stall_q  = lsu_vld && !lsu_rdy;
            held_bus = lsu_bus;
        end else begin
            br_due  = 1'b0;
            stall_q = 1'b0;
        end

        if (end_check && !end_done) begin
            end_done = 1'b1;
            if (load_err || n_lines == 0) begin
                report("golden file could not be read");
            end
            if (q.size() != 0) begin
                report("accepted items were still waiting in the LSU stage");
            end
            if (line_idx != n_lines) begin
                report($sformatf("only %0d of %0d golden lines were issued", line_idx, n_lines));
            end
        end
        items_pending = q.size();
        reset_q       = reset;
    end

endmodule

// ==== sim/tb_exu_top.sv ====
module tb_exu_top;

    localparam int br_aw     = 12;
    localparam int max_lines = 64;
    localparam int timeout   = 200;

    logic        clk;
    logic        reset;
    logic        issue_vld;
    logic [4:0]  issue_op;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] imm;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic        lsu_rdy;
    logic        end_check;

    logic             issue_rdy;
    logic             flush;
    logic             rf_wb_vld;
    logic [4:0]       rf_wb_addr;
    logic [31:0]      rf_wb_data;
    logic             ld_pending;
    logic             br_vld;
    logic [br_aw-1:0] br_addr;
    logic             lsu_vld;
    logic             lsu_wb_vld;
    logic [4:0]       lsu_wb_addr;
    logic [31:0]      lsu_wb_data;
    logic [4:0]       lsu_mem_op;
    logic [11:0]      lsu_sram_addr;
    logic             lsu_ld_iram;
    logic             lsu_ld_oram;
    logic             lsu_ld_wram;
    logic             lsu_st_iram;
    logic             lsu_st_oram;
    logic             lsu_st_wram;
    logic [31:0]      lsu_st_data;

    int mismatch_cnt;
    int other_cnt;
    int items_pending;

    // stimulus columns of the golden file
    logic [31:0] s_op [max_lines];
    logic [31:0] s_src1 [max_lines];
    logic [31:0] s_src2 [max_lines];
    logic [31:0] s_imm [max_lines];
    logic [31:0] s_pc [max_lines];
    logic [31:0] s_wb_en [max_lines];
    logic [31:0] s_wb_addr [max_lines];
    int          n_lines;
    logic [15:0] lfsr_state;
    bit          aborted;

    tb_clk_gen #(.period(8)) u_clk_gen (.clk(clk));

    exu_top #(.br_aw(br_aw)) u_exu_top (
        .clk(clk), .reset(reset),
        .issue_vld(issue_vld), .issue_op(issue_op),
        .src1(src1), .src2(src2), .imm(imm), .pc(pc),
        .wb_en(wb_en), .wb_addr(wb_addr),
        .issue_rdy(issue_rdy), .flush(flush),
        .rf_wb_vld(rf_wb_vld), .rf_wb_addr(rf_wb_addr), .rf_wb_data(rf_wb_data),
        .ld_pending(ld_pending), .br_vld(br_vld), .br_addr(br_addr),
        .lsu_rdy(lsu_rdy), .lsu_vld(lsu_vld), .lsu_wb_vld(lsu_wb_vld),
        .lsu_wb_addr(lsu_wb_addr), .lsu_wb_data(lsu_wb_data),
        .lsu_mem_op(lsu_mem_op), .lsu_sram_addr(lsu_sram_addr),
        .lsu_ld_iram(lsu_ld_iram), .lsu_ld_oram(lsu_ld_oram), .lsu_ld_wram(lsu_ld_wram),
        .lsu_st_iram(lsu_st_iram), .lsu_st_oram(lsu_st_oram), .lsu_st_wram(lsu_st_wram),
        .lsu_st_data(lsu_st_data)
    );

    exu_checker #(.br_aw(br_aw), .max_lines(max_lines)) u_exu_checker (
        .clk(clk), .reset(reset), .end_check(end_check),
        .issue_vld(issue_vld), .issue_op(issue_op), .issue_rdy(issue_rdy), .flush(flush),
        .rf_wb_vld(rf_wb_vld), .rf_wb_addr(rf_wb_addr), .rf_wb_data(rf_wb_data),
        .ld_pending(ld_pending), .br_vld(br_vld), .br_addr(br_addr),
        .lsu_rdy(lsu_rdy), .lsu_vld(lsu_vld), .lsu_wb_vld(lsu_wb_vld),
        .lsu_wb_addr(lsu_wb_addr), .lsu_wb_data(lsu_wb_data),
        .lsu_mem_op(lsu_mem_op), .lsu_sram_addr(lsu_sram_addr),
        .lsu_ld_iram(lsu_ld_iram), .lsu_ld_oram(lsu_ld_oram), .lsu_ld_wram(lsu_ld_wram),
        .lsu_st_iram(lsu_st_iram), .lsu_st_oram(lsu_st_oram), .lsu_st_wram(lsu_st_wram),
        .lsu_st_data(lsu_st_data),
        .mismatch_cnt(mismatch_cnt), .other_cnt(other_cnt), .items_pending(items_pending)
    );

    // galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    task automatic read_stimulus();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f [13];
        n_lines = 0;
        fd = $fopen("sim/exu_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/exu_golden.txt");
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd) && n_lines < max_lines) begin
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                         f[7], f[8], f[9], f[10], f[11], f[12]);
            if (rc != 13) begin
                continue;
            end
            s_op[n_lines]      = f[0];
            s_src1[n_lines]    = f[1];
            s_src2[n_lines]    = f[2];
            s_imm[n_lines]     = f[3];
            s_pc[n_lines]      = f[4];
            s_wb_en[n_lines]   = f[5];
            s_wb_addr[n_lines] = f[6];
            n_lines++;
        end
        $fclose(fd);
    endtask

    // next back-pressure bit for the lsu
    task automatic step_lsu_rdy();
        lsu_rdy    <= lfsr_state[0];
        lfsr_state  = lfsr_next(lfsr_state);
    endtask

    initial begin
        int  wait_cnt;
        bit  done;
        reset      = 1'b1;
        issue_vld  = 1'b0;
        issue_op   = 5'd31;
        src1       = '0;
        src2       = '0;
        imm        = '0;
        pc         = '0;
        wb_en      = 1'b0;
        wb_addr    = '0;
        lsu_rdy    = 1'b1;
        end_check  = 1'b0;
        lfsr_state = 16'd70;
        aborted    = 1'b0;
        read_stimulus();
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < n_lines && !aborted; i++) begin
            issue_vld <= 1'b1;
            issue_op  <= s_op[i][4:0];
            src1      <= s_src1[i];
            src2      <= s_src2[i];
            imm       <= s_imm[i];
            pc        <= s_pc[i];
            wb_en     <= s_wb_en[i][0];
            wb_addr   <= s_wb_addr[i][4:0];
            wait_cnt = 0;
            done     = 1'b0;
            // flush discards the held instruction, otherwise wait for ready
            while (!done && !aborted) begin
                @(posedge clk);
                if (flush || issue_rdy) begin
                    done = 1'b1;
                end else begin
                    wait_cnt++;
                    if (wait_cnt > timeout) begin
                        $display("timed out waiting for issue_rdy on line %0d", i);
                        aborted = 1'b1;
                    end
                end
                step_lsu_rdy();
            end
        end
        issue_vld <= 1'b0;
        issue_op  <= 5'd31;

        wait_cnt = 0;
        @(negedge clk);
        while (items_pending != 0 && !aborted) begin
            @(posedge clk);
            step_lsu_rdy();
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > timeout) begin
                $display("timed out waiting for the LSU stage to drain");
                aborted = 1'b1;
            end
        end
        @(posedge clk);
        end_check <= 1'b1;
        @(posedge clk);
        @(negedge clk);

        $display("errors: %0d mismatches, %0d other failures, aborted %0d",
                 mismatch_cnt, other_cnt, aborted);
        if (aborted || mismatch_cnt != 0 || other_cnt != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

// ==== sim/exu_golden.txt ====
# op src1 src2 imm pc wb_en wb_addr killed exp_data exp_taken exp_br exp_sram exp_sel
# exp_sel bits: 0 ld_iram, 1 ld_oram, 2 ld_wram, 3 st_iram, 4 st_oram, 5 st_wram
00 00000005 00000007 00000000 00000010 1 01 0 0000000c 0 000 000 00
01 00000003 00000005 00000000 00000014 1 02 0 fffffffe 0 000 000 00
02 ffffffff 00000001 00000000 00000018 1 03 0 00000001 0 000 000 00
03 ffffffff 00000001 00000000 0000001c 1 04 0 00000000 0 000 000 00
04 f0f0f0f0 0ff00ff0 00000000 00000020 1 05 0 ff00ff00 0 000 000 00
05 12340000 00005678 00000000 00000024 1 06 0 12345678 0 000 000 00
06 ff00ff00 0f0f0f0f 00000000 00000028 1 07 0 0f000f00 0 000 000 00
07 00000001 00000024 00000000 0000002c 1 08 0 00000010 0 000 000 00
08 80000000 00000004 00000000 00000030 1 09 0 08000000 0 000 000 00
09 80000000 00000004 00000000 00000034 1 0a 0 f8000000 0 000 000 00
0a 00000000 12345000 00000000 00000038 1 0b 0 12345000 0 000 000 00
0b 00000000 00001000 00000000 00000100 1 0c 0 00001100 0 000 000 00
10 ffffffff 00000001 00000040 00000200 0 00 0 00000000 1 240 000 00
00 00000001 00000001 00000000 00000204 1 0e 1 00000002 0 000 000 00
12 ffffffff 00000001 00000040 00000300 0 00 0 00000000 0 000 000 00
0c 00000000 00000080 00000000 00000400 1 01 0 00000404 1 480 000 00
16 00000000 00000010 00000000 00000404 1 0f 1 00000000 0 000 010 01
0d 00001234 00000010 00000000 00000500 1 1f 0 00000504 1 244 000 00
01 00000009 00000001 00000000 00000504 1 10 1 00000008 0 000 000 00
0e 00000007 00000007 fffffff0 00000600 0 00 0 00000000 1 5f0 000 00
04 00000001 00000002 00000000 00000604 1 11 1 00000003 0 000 000 00
0f 00000005 00000005 00000010 00000700 0 00 0 00000000 0 000 000 00
16 00000000 00000123 00000000 00000710 1 0a 0 00000000 0 000 123 01
15 00001000 00000010 00000000 00000714 1 0b 0 00000000 0 000 010 02
17 00002000 00000ffc 00000000 00000718 1 0c 0 00000000 0 000 ffc 04
14 00003000 00000005 00000000 0000071c 1 0d 0 00000000 0 000 005 00
1b 00001000 deadbeef 00000020 00000720 0 00 0 00000000 0 000 020 10
19 00000000 000000aa 00000abc 00000724 0 00 0 00000000 0 000 abc 08
1a 00002100 00001234 00000100 00000728 0 00 0 00000000 0 000 200 20
1b ffff0000 cafef00d 00002004 0000072c 0 00 0 00000000 0 000 004 20
11 00000001 ffffffff 00000020 00000800 0 00 0 00000000 1 820 000 00
1b 00000000 11111111 00000010 00000804 0 00 1 00000000 0 000 010 10
13 00000001 ffffffff 00000008 00000900 0 00 0 00000000 0 000 000 00
00 00000003 00000004 00000000 00000904 1 03 0 00000007 0 000 000 00
1f 00000000 00000000 00000000 00000908 0 00 0 00000000 0 000 000 00

// ==== filelist.f ====
source/exu_pkg.sv
source/exu_ctrl.sv
source/alu_core.sv
source/branch_unit.sv
source/lsu_addr_gen.sv
source/exu_lsu_reg.sv
source/exu_top.sv
sim/tb_clk_gen.sv
sim/exu_checker.sv
sim/tb_exu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_exu_top \
    -f filelist.f \
    -o tb_exu_top

./obj_dir/tb_exu_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
